// File: verilog/gfe_settings.svh
`ifndef GFE_SETTINGS_SVH
`define GFE_SETTINGS_SVH

// array is square in columns, triangular in cells
`define GFE_N 4

// one GF(4) element
`define GFE_ELEM_W 2

// packed row, column c in bits 2c+1..2c
`define GFE_ROW_W 8

// input sample edge to output register edge
`define GFE_LATENCY 8

`endif

// File: verilog/gfe_pkg.sv
`include "gfe_settings.svh"

package gfe_pkg;

  ////////////////////////////////////////////////////////////
  // types

  typedef logic [`GFE_ELEM_W-1:0] gf_elem_t;

  // row operation issued by a diagonal cell
  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_LOAD = 2'd1,
    OP_ELIM = 2'd2,
    OP_SKIP = 2'd3
  } op_code_t;

  // one column slot of a row on its way down
  typedef struct packed {
    logic     valid;
    logic     start;
    gf_elem_t element;
    logic     independent;
    logic     full_rank;
  } lane_t;

  ////////////////////////////////////////////////////////////
  // GF(4) arithmetic, polynomial x^2 + x + 1

  function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
    logic hi;
    hi = a[1] & b[1];
    // x^2 term folds back into x + 1
    return {hi ^ (a[1] & b[0]) ^ (a[0] & b[1]), hi ^ (a[0] & b[0])};
  endfunction

  function automatic gf_elem_t gf_inv(input gf_elem_t a);
    gf_elem_t r;
    case (a)
      2'd2: r = 2'd3;
      2'd3: r = 2'd2;
      // 1 is its own inverse, 0 never reaches here
      default: r = a;
    endcase
    return r;
  endfunction

endpackage

// File: verilog/elim_op_if.sv
`timescale 1ns/100ps

// row operation moving right along one array row
interface elim_op_if;
  gfe_pkg::op_code_t op;
  gfe_pkg::gf_elem_t fac;
  // diagonal took this data row as its pivot
  logic new_pivot;
  // diagonal holds a pivot after this data row
  logic all_held;

  modport issuer (
    output op,
    output fac,
    output new_pivot,
    output all_held
  );

  modport receiver (
    input op,
    input fac,
    input new_pivot,
    input all_held
  );
endinterface

// File: verilog/pivot_cell.sv
`timescale 1ns/100ps

module pivot_cell (
  input  logic           clk,
  input  logic           rst,
  input  gfe_pkg::lane_t lane_in,
  output gfe_pkg::lane_t lane_out,
  elim_op_if.issuer      op
);

  logic              held;
  logic              held_eff;
  logic              held_next;
  logic              load;
  gfe_pkg::op_code_t op_next;
  gfe_pkg::gf_elem_t fac_next;
  gfe_pkg::lane_t    lane_next;

  // a new matrix forgets the old pivot before this row is looked at
  assign held_eff = held & ~lane_in.start;

  always_comb begin
    load = 1'b0;
    op_next = gfe_pkg::OP_NONE;
    fac_next = '0;
    if (lane_in.valid) begin
      if (held_eff) begin
        op_next = gfe_pkg::OP_ELIM;
        fac_next = lane_in.element;
      end else if (lane_in.element != '0) begin
        // normalize so the stored leading element is 1
        load = 1'b1;
        op_next = gfe_pkg::OP_LOAD;
        fac_next = gfe_pkg::gf_inv(lane_in.element);
      end else begin
        op_next = gfe_pkg::OP_SKIP;
      end
    end
  end

  assign held_next = held_eff | load;

  always_comb begin
    lane_next = lane_in;
    // nothing below the diagonal, column is zero from here on
    lane_next.element = '0;
    lane_next.independent = lane_in.independent | load;
    lane_next.full_rank = lane_in.full_rank & held_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else if (lane_in.valid) begin
      held <= held_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_out <= '0;
      op.op <= gfe_pkg::OP_NONE;
      op.fac <= '0;
      op.new_pivot <= 1'b0;
      op.all_held <= 1'b0;
    end else begin
      lane_out <= lane_next;
      op.op <= op_next;
      op.fac <= fac_next;
      op.new_pivot <= load;
      op.all_held <= held_next;
    end
  end

endmodule

// File: verilog/update_cell.sv
`timescale 1ns/100ps

module update_cell (
  input  logic           clk,
  input  logic           rst,
  input  gfe_pkg::lane_t lane_in,
  output gfe_pkg::lane_t lane_out,
  elim_op_if.receiver    op_in,
  elim_op_if.issuer      op_out
);

  // this cell's element of the normalized pivot row
  gfe_pkg::gf_elem_t pivot_elem;
  gfe_pkg::lane_t    lane_next;

  always_comb begin
    lane_next = lane_in;
    lane_next.independent = lane_in.independent | op_in.new_pivot;
    lane_next.full_rank = lane_in.full_rank & op_in.all_held;
    case (op_in.op)
      gfe_pkg::OP_LOAD: begin
        lane_next.element = '0;
      end
      gfe_pkg::OP_ELIM: begin
        // subtraction is xor in GF(4)
        lane_next.element = lane_in.element ^ gfe_pkg::gf_mul(op_in.fac, pivot_elem);
      end
      // skip and idle pass the element through
      default: begin
        lane_next.element = lane_in.element;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (lane_in.valid) begin
      if (op_in.op == gfe_pkg::OP_LOAD) begin
        pivot_elem <= gfe_pkg::gf_mul(op_in.fac, lane_in.element);
      end else if (lane_in.start) begin
        pivot_elem <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lane_out <= '0;
      op_out.op <= gfe_pkg::OP_NONE;
      op_out.fac <= '0;
      op_out.new_pivot <= 1'b0;
      op_out.all_held <= 1'b0;
    end else begin
      lane_out <= lane_next;
      // same op one cell further right and one cycle later
      op_out.op <= op_in.op;
      op_out.fac <= op_in.fac;
      op_out.new_pivot <= op_in.new_pivot;
      op_out.all_held <= op_in.all_held;
    end
  end

endmodule

// File: verilog/gfe_array.sv
`timescale 1ns/100ps
`include "gfe_settings.svh"

module gfe_array (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  input  logic                  in_start,
  input  logic [`GFE_ROW_W-1:0] in_row,
  output logic                  out_valid,
  output logic                  out_independent,
  output logic                  out_full_rank
);

  logic                  in_valid_q;
  logic                  in_start_q;
  logic [`GFE_ROW_W-1:0] in_row_q;

  // lane entering row 0 of each column, after skew
  gfe_pkg::lane_t top_lane [`GFE_N];
  // lane leaving cell (r,c), only c >= r exists
  gfe_pkg::lane_t cell_lane [`GFE_N][`GFE_N];

  ////////////////////////////////////////////////////////////
  // input register

  always_ff @(posedge clk) begin
    if (rst) begin
      in_valid_q <= 1'b0;
      in_start_q <= 1'b0;
    end else begin
      in_valid_q <= in_valid;
      in_start_q <= in_start;
    end
  end

  always_ff @(posedge clk) begin
    in_row_q <= in_row;
  end

  ////////////////////////////////////////////////////////////
  // column skew, column c waits c more cycles

  for (genvar c = 0; c < `GFE_N; c++) begin : gen_skew
    gfe_pkg::lane_t col_lane;

    // independent starts false, full_rank starts true
    assign col_lane = '{
      valid:       in_valid_q,
      start:       in_start_q,
      element:     in_row_q[`GFE_ELEM_W*c +: `GFE_ELEM_W],
      independent: 1'b0,
      full_rank:   1'b1
    };

    if (c == 0) begin : gen_direct
      assign top_lane[c] = col_lane;
    end else begin : gen_delay
      gfe_pkg::lane_t dly_q [c];

      always_ff @(posedge clk) begin
        if (rst) begin
          for (int i = 0; i < c; i++) begin
            dly_q[i] <= '0;
          end
        end else begin
          dly_q[0] <= col_lane;
          for (int i = 1; i < c; i++) begin
            dly_q[i] <= dly_q[i-1];
          end
        end
      end

      assign top_lane[c] = dly_q[c-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // triangle of cells, pivot on the diagonal

  for (genvar r = 0; r < `GFE_N; r++) begin : gen_row
    // link j is driven by cell (r, r+j)
    elim_op_if op_link [`GFE_N - r] ();

    for (genvar j = 0; j < `GFE_N - r; j++) begin : gen_cell
      localparam int COL = r + j;
      gfe_pkg::lane_t lane_in;

      if (r == 0) begin : gen_top
        assign lane_in = top_lane[COL];
      end else begin : gen_below
        assign lane_in = cell_lane[r-1][COL];
      end

      if (j == 0) begin : gen_pivot
        pivot_cell pivot_i (
          .clk      (clk),
          .rst      (rst),
          .lane_in  (lane_in),
          .lane_out (cell_lane[r][COL]),
          .op       (op_link[0])
        );
      end else begin : gen_update
        update_cell update_i (
          .clk      (clk),
          .rst      (rst),
          .lane_in  (lane_in),
          .lane_out (cell_lane[r][COL]),
          .op_in    (op_link[j-1]),
          .op_out   (op_link[j])
        );
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output register, fed by the last diagonal cell

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= cell_lane[`GFE_N-1][`GFE_N-1].valid;
    end
  end

  always_ff @(posedge clk) begin
    out_independent <= cell_lane[`GFE_N-1][`GFE_N-1].independent;
    out_full_rank <= cell_lane[`GFE_N-1][`GFE_N-1].full_rank;
  end

endmodule

// File: verif/gfe_array_sva.sv
`timescale 1ns/100ps
`include "gfe_settings.svh"

module gfe_array_sva (
  input logic clk,
  input logic rst,
  input logic in_valid,
  input logic out_valid,
  input logic out_independent,
  input logic out_full_rank
);

  // full_rank of the last row that came out
  logic last_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_full <= 1'b0;
    end else if (out_valid) begin
      last_full <= out_full_rank;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid ##1 !out_valid)
    else $error("out_valid high during or right after reset");

  // sampled one edge after the output register updates
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, `GFE_LATENCY + 1))
    else $error("out_valid does not follow in_valid at the fixed latency");

  a_known: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !$isunknown({out_independent, out_full_rank}))
    else $error("unknown result with out_valid high");

  a_rank_rise: assert property (@(posedge clk) disable iff (rst)
    (out_valid && out_full_rank && !out_independent) |-> last_full)
    else $error("full rank reached on a dependent row");

endmodule

// File: verif/gfe_array_tb.sv
`timescale 1ns/100ps
`include "gfe_settings.svh"

module gfe_array_tb;

  localparam int DRAIN_TIMEOUT = 4 * `GFE_LATENCY;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic                  in_start;
  logic [`GFE_ROW_W-1:0] in_row;
  logic                  out_valid;
  logic                  out_independent;
  logic                  out_full_rank;

  integer seed;
  int     errors;
  int     checks;
  int     cyc;

  // expected {independent, full_rank} and arrival cycle in send order
  logic [1:0] exp_q [$];
  int         exp_cyc_q [$];
  logic [1:0] exp_res;
  int         exp_cyc;

  // reference model state with normalized pivot rows
  logic                  piv_held [`GFE_N];
  logic [`GFE_ELEM_W-1:0] piv_row [`GFE_N][`GFE_N];

  gfe_array gfe_array_i (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .in_start        (in_start),
    .in_row          (in_row),
    .out_valid       (out_valid),
    .out_independent (out_independent),
    .out_full_rank   (out_full_rank)
  );

  bind gfe_array gfe_array_sva sva_i (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .out_valid       (out_valid),
    .out_independent (out_independent),
    .out_full_rank   (out_full_rank)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // GF(4) reference arithmetic

  function automatic logic [1:0] poly_mul(input logic [1:0] a, input logic [1:0] b);
    logic [2:0] p;
    p = 3'd0;
    // shift and add then fold x^2 back with x^2 + x + 1
    for (int i = 0; i < 2; i++) begin
      if (b[i]) begin
        p = p ^ ({1'b0, a} << i);
      end
    end
    if (p[2]) begin
      p = p ^ 3'b111;
    end
    return p[1:0];
  endfunction

  function automatic logic [1:0] find_inverse(input logic [1:0] a);
    logic [1:0] r;
    r = 2'd0;
    for (int b = 1; b < 4; b++) begin
      if (poly_mul(a, 2'(b)) == 2'd1) begin
        r = 2'(b);
      end
    end
    return r;
  endfunction

  // row is independent when it leaves a nonzero leading element behind
  task automatic model_row(input logic start, input logic [`GFE_ROW_W-1:0] row,
                           output logic indep, output logic full);
    logic [1:0] e [`GFE_N];
    logic [1:0] f;
    logic       done;
    for (int c = 0; c < `GFE_N; c++) begin
      e[c] = row[`GFE_ELEM_W*c +: `GFE_ELEM_W];
      if (start) begin
        piv_held[c] = 1'b0;
      end
    end
    indep = 1'b0;
    done = 1'b0;
    for (int c = 0; c < `GFE_N; c++) begin
      if (!done && piv_held[c]) begin
        f = e[c];
        for (int j = 0; j < `GFE_N; j++) begin
          e[j] = e[j] ^ poly_mul(f, piv_row[c][j]);
        end
      end else if (!done && e[c] != 2'd0) begin
        f = find_inverse(e[c]);
        for (int j = 0; j < `GFE_N; j++) begin
          piv_row[c][j] = poly_mul(f, e[j]);
        end
        piv_held[c] = 1'b1;
        indep = 1'b1;
        done = 1'b1;
      end
    end
    full = 1'b1;
    for (int c = 0; c < `GFE_N; c++) begin
      full = full & piv_held[c];
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and checking

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("Fail %s: got %h expected %h at cycle %0d", name, got, want, cyc);
    end
  endtask

  task automatic send_row(input logic start, input logic [`GFE_ROW_W-1:0] row);
    logic indep;
    logic full;
    model_row(start, row, indep, full);
    exp_q.push_back({indep, full});
    exp_cyc_q.push_back(cyc + 1 + `GFE_LATENCY);
    in_valid = 1'b1;
    in_start = start;
    in_row = row;
    @(posedge clk);
    #10;
    in_valid = 1'b0;
    in_start = 1'b0;
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    in_start = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #10;
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("timeout with %0d results still missing at cycle %0d", exp_q.size(), cyc);
    end
  endtask

  // collector
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("out_valid high with no row in flight at cycle %0d", cyc);
      end else begin
        exp_res = exp_q.pop_front();
        exp_cyc = exp_cyc_q.pop_front();
        check("out_cycle", 32'(cyc), 32'(exp_cyc));
        check("out_independent", 32'(out_independent), 32'(exp_res[1]));
        check("out_full_rank", 32'(out_full_rank), 32'(exp_res[0]));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // tests

  task automatic reset_sequence();
    rst = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #10;
      check("out_valid", 32'(out_valid), 32'd0);
    end
    rst = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #10;
      check("out_valid", 32'(out_valid), 32'd0);
    end
  endtask

  task automatic full_rank_matrices();
    // identity then a sum of two of its rows
    send_row(1'b1, 8'h01);
    send_row(1'b0, 8'h04);
    send_row(1'b0, 8'h10);
    send_row(1'b0, 8'h40);
    send_row(1'b0, 8'h05);
    wait_drain();
    // scaled permutation
    send_row(1'b1, 8'h20);
    send_row(1'b0, 8'h03);
    send_row(1'b0, 8'h80);
    send_row(1'b0, 8'h0c);
    send_row(1'b0, 8'hff);
    wait_drain();
  endtask

  task automatic singular_matrix();
    send_row(1'b1, 8'h01);
    send_row(1'b0, 8'h00);
    send_row(1'b0, 8'h01);
    send_row(1'b0, 8'h24);
    // 3 times the row above
    send_row(1'b0, 8'h1c);
    send_row(1'b0, 8'h25);
    wait_drain();
  endtask

  task automatic back_to_back_matrices();
    send_row(1'b1, 8'h01);
    send_row(1'b0, 8'h04);
    send_row(1'b0, 8'h10);
    send_row(1'b0, 8'h40);
    send_row(1'b1, 8'h55);
    send_row(1'b0, 8'h14);
    send_row(1'b0, 8'haa);
    send_row(1'b0, 8'hc3);
    send_row(1'b1, 8'h08);
    wait_drain();
  endtask

  task automatic random_rows();
    logic [31:0]           rnd;
    logic [31:0]           mask;
    logic [`GFE_ROW_W-1:0] row;
    int                    until_start;
    until_start = 0;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      mask = $random(seed);
      // bias toward zero elements so dependent rows show up
      row = rnd[7:0] & (mask[7:0] | mask[15:8]);
      if (until_start == 0) begin
        rnd = $random(seed);
        until_start = 4 + int'(rnd % 32'd3);
        send_row(1'b1, row);
      end else begin
        send_row(1'b0, row);
      end
      until_start--;
      rnd = $random(seed);
      if (rnd[3:2] == 2'd0) begin
        idle(1 + int'(rnd[1:0]));
      end
    end
    wait_drain();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    in_valid = 1'b0;
    in_start = 1'b0;
    in_row = '0;
    errors = 0;
    checks = 0;
    seed = 32'h253141db;
    for (int c = 0; c < `GFE_N; c++) begin
      piv_held[c] = 1'b0;
    end
    reset_sequence();
    full_rank_matrices();
    singular_matrix();
    back_to_back_matrices();
    random_rows();
    idle(2);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: gfe_array.f
+incdir+verilog
verilog/gfe_pkg.sv
verilog/elim_op_if.sv
verilog/pivot_cell.sv
verilog/update_cell.sv
verilog/gfe_array.sv
verif/gfe_array_sva.sv
verif/gfe_array_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the gfe_array testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f gfe_array.f --top-module gfe_array_tb -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/Vgfe_array_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
